// File: Bender.yml
package:
  name: lsu_subsystem

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/lsu_pkg.sv
      - design/lsu_decode.sv
      - design/lsu_execute.sv
      - design/main_memory.sv
      - design/lsu_result.sv
      - design/lsu_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/lsu_props.sv
      - sim/lsu_checker.sv
      - sim/lsu_tb.sv

// File: design/lsu_decode.sv
// LSU decode stage
// takes one request while the path is idle and registers its bus form:
// word address, byte lanes, lane-shifted store data and a misalignment flag

`default_nettype none

`include "lsu_defines.svh"

module lsu_decode (
    input  wire                logic i_clk,
    input  wire                logic i_rst,
    input  wire                logic i_req_valid,
    input  lsu_pkg::lsu_req_t  i_req,
    input  wire                logic i_idle,
    output lsu_pkg::lsu_dec_t  o_dec,
    output logic               o_dec_valid
);

    logic              accept;
    lsu_pkg::lsu_dec_t dec_next;

    // strobes seen while busy are simply dropped
    assign accept = i_req_valid && i_idle;

    always_comb
    begin
        dec_next.is_store = i_req.is_store;
        dec_next.funct3   = i_req.funct3;
        dec_next.waddr    = i_req.addr[`LSU_AW-1:2];
        dec_next.offset   = i_req.addr[1:0];
        // store data moved up to the lane of its first byte
        dec_next.wdata    = i_req.wdata << {i_req.addr[1:0], 3'b000};

        case (i_req.funct3)
            lsu_pkg::LB, lsu_pkg::LBU:
            begin
                dec_next.sel        = lsu_pkg::sel_t'(4'b0001) << i_req.addr[1:0];
                dec_next.misaligned = 1'b0;
            end
            lsu_pkg::LH, lsu_pkg::LHU:
            begin
                // halves at offset 3 spill out of the word, caught by misaligned
                dec_next.sel        = lsu_pkg::sel_t'(4'b0011) << i_req.addr[1:0];
                dec_next.misaligned = i_req.addr[0];
            end
            default:
            begin
                // word access, also covers unused codes
                dec_next.sel        = 4'b1111;
                dec_next.misaligned = |i_req.addr[1:0];
            end
        endcase
    end

    // valid pulse, one per accepted request
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_dec_valid <= 1'b0;
        else
            o_dec_valid <= accept;
    end

    // decoded payload, held until the next acceptance
    always_ff @(posedge i_clk)
    begin
        if (accept)
            o_dec <= dec_next;
    end

endmodule

`default_nettype wire

// File: design/lsu_defines.svh
// LSU widths and memory size
// data width, memory depth in bytes and the byte address width derived from it

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// core data width
`define LSU_XLEN 32

// data memory depth in bytes, power of two
`define LSU_MEM_BYTES 1024

// byte address width, log2 of the memory depth
`define LSU_AW $clog2(`LSU_MEM_BYTES)

`endif

// File: design/lsu_execute.sv
// LSU execute stage
// wishbone classic master, one bus cycle per aligned access;
// misaligned accesses complete at once without touching the bus

`default_nettype none

module lsu_execute (
    input  wire                logic i_clk,
    input  wire                logic i_rst,
    input  lsu_pkg::lsu_dec_t  i_dec,
    input  wire                logic i_dec_valid,
    output logic               o_wb_cyc,
    output logic               o_wb_stb,
    output logic               o_wb_we,
    output lsu_pkg::waddr_t    o_wb_addr,
    output lsu_pkg::word_t     o_wb_data,
    output lsu_pkg::sel_t      o_wb_sel,
    input  wire                logic i_wb_ack,
    input  lsu_pkg::word_t     i_wb_data,
    output logic               o_cmpl,
    output lsu_pkg::lsu_dec_t  o_cmpl_dec,
    output lsu_pkg::word_t     o_rdata_raw,
    output logic               o_busy
);

    lsu_pkg::bus_state_t state_q;
    lsu_pkg::lsu_dec_t   dec_q;
    logic                miss_q;    // completion of a misaligned access

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state_q <= lsu_pkg::IDLE;
            miss_q  <= 1'b0;
        end
        else
        begin
            miss_q <= 1'b0;
            case (state_q)
                lsu_pkg::IDLE:
                begin
                    if (i_dec_valid && i_dec.misaligned)
                        miss_q <= 1'b1;
                    else if (i_dec_valid)
                        state_q <= lsu_pkg::WAIT_ACK;
                end
                lsu_pkg::WAIT_ACK:
                begin
                    // memory never stalls, ack closes the cycle
                    if (i_wb_ack)
                        state_q <= lsu_pkg::IDLE;
                end
                default: state_q <= lsu_pkg::IDLE;
            endcase
        end
    end

    // hold the access for the bus and for the result stage
    always_ff @(posedge i_clk)
    begin
        if (i_dec_valid)
            dec_q <= i_dec;
    end

    // cyc spans the whole cycle
    assign o_wb_cyc  = (state_q == lsu_pkg::WAIT_ACK);
    // stb falls with ack so the slave sees exactly one strobe
    assign o_wb_stb  = o_wb_cyc && !i_wb_ack;
    assign o_wb_we   = dec_q.is_store;
    assign o_wb_addr = dec_q.waddr;
    assign o_wb_data = dec_q.wdata;
    assign o_wb_sel  = dec_q.sel;

    assign o_cmpl      = miss_q || (o_wb_cyc && i_wb_ack);
    assign o_cmpl_dec  = dec_q;
    assign o_rdata_raw = i_wb_data;

    // dec_valid term covers the cycle between acceptance and the fsm
    assign o_busy = i_dec_valid || o_wb_cyc || miss_q;

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
// LSU types
// data and address vectors, funct3 width codes, request and decoded records
// and the wishbone master states

`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

    // data word as carried on the bus
    typedef logic [`LSU_XLEN-1:0] word_t;

    // byte address into the data memory
    typedef logic [`LSU_AW-1:0] addr_t;

    // word address, low two byte bits dropped
    typedef logic [`LSU_AW-3:0] waddr_t;

    // one bit per byte lane
    typedef logic [3:0] sel_t;

    // risc-v funct3 load codes, stores reuse 0..2
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd4,
        LHU = 3'd5
    } funct3_t;

    // request as seen at the top-level port
    typedef struct packed {
        logic    is_store;
        funct3_t funct3;
        addr_t   addr;
        word_t   wdata;
    } lsu_req_t;

    // request after lane decode
    typedef struct packed {
        logic       is_store;
        funct3_t    funct3;
        waddr_t     waddr;
        logic [1:0] offset;
        sel_t       sel;
        word_t      wdata;      // already shifted into its lanes
        logic       misaligned;
    } lsu_dec_t;

    // wishbone master
    typedef enum logic {
        IDLE,
        WAIT_ACK
    } bus_state_t;

endpackage

`default_nettype wire

// File: design/lsu_result.sv
// LSU result stage
// picks the addressed byte or half from the bus word, extends it per funct3
// and registers done, read data and fault

`default_nettype none

`include "lsu_defines.svh"

module lsu_result (
    input  wire                logic i_clk,
    input  wire                logic i_rst,
    input  wire                logic i_cmpl,
    input  lsu_pkg::lsu_dec_t  i_cmpl_dec,
    input  lsu_pkg::word_t     i_rdata_raw,
    output logic               o_done,
    output lsu_pkg::word_t     o_rdata,
    output logic               o_fault
);

    lsu_pkg::word_t shifted;
    lsu_pkg::word_t ext;
    logic           load_ok;

    // addressed byte lands in bits 7:0
    assign shifted = i_rdata_raw >> {i_cmpl_dec.offset, 3'b000};

    always_comb
    begin
        case (i_cmpl_dec.funct3)
            lsu_pkg::LB:  ext = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::LH:  ext = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::LBU: ext = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            lsu_pkg::LHU: ext = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            default:      ext = i_rdata_raw;   // LW, whole word
        endcase
    end

    // stores and faults return zero
    assign load_ok = !i_cmpl_dec.is_store && !i_cmpl_dec.misaligned;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_done  <= 1'b0;
            o_fault <= 1'b0;
        end
        else
        begin
            o_done  <= i_cmpl;
            o_fault <= i_cmpl && i_cmpl_dec.misaligned;
        end
    end

    // data is only meaningful with done
    always_ff @(posedge i_clk)
    begin
        if (i_cmpl)
            o_rdata <= load_ok ? ext : '0;
    end

endmodule

`default_nettype wire

// File: design/lsu_top.sv
// LSU top
// decode, wishbone master, data memory and result stage in a chain;
// one access in flight, o_busy gates new requests

`default_nettype none

module lsu_top (
    input  wire               logic i_clk,
    input  wire               logic i_rst,
    input  wire               logic i_req_valid,
    input  lsu_pkg::lsu_req_t i_req,
    output logic              o_busy,
    output logic              o_done,
    output lsu_pkg::word_t    o_rdata,
    output logic              o_fault
);

    // decode to execute
    lsu_pkg::lsu_dec_t dec;
    logic              dec_valid;

    // wishbone
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    lsu_pkg::waddr_t   wb_addr;
    lsu_pkg::word_t    wb_wdata;
    lsu_pkg::sel_t     wb_sel;
    logic              wb_ack;
    lsu_pkg::word_t    wb_rdata;

    // execute to result
    logic              cmpl;
    lsu_pkg::lsu_dec_t cmpl_dec;
    lsu_pkg::word_t    bus_rdata;

    lsu_decode u_decode (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .i_idle      (!o_busy),
        .o_dec       (dec),
        .o_dec_valid (dec_valid)
    );

    lsu_execute u_execute (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_dec       (dec),
        .i_dec_valid (dec_valid),
        .o_wb_cyc    (wb_cyc),
        .o_wb_stb    (wb_stb),
        .o_wb_we     (wb_we),
        .o_wb_addr   (wb_addr),
        .o_wb_data   (wb_wdata),
        .o_wb_sel    (wb_sel),
        .i_wb_ack    (wb_ack),
        .i_wb_data   (wb_rdata),
        .o_cmpl      (cmpl),
        .o_cmpl_dec  (cmpl_dec),
        .o_rdata_raw (bus_rdata),
        .o_busy      (o_busy)
    );

    main_memory u_mem (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (wb_stb),
        .i_wb_we   (wb_we),
        .i_wb_addr (wb_addr),
        .i_wb_data (wb_wdata),
        .i_wb_sel  (wb_sel),
        .o_wb_ack  (wb_ack),
        .o_wb_data (wb_rdata)
    );

    lsu_result u_result (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_cmpl      (cmpl),
        .i_cmpl_dec  (cmpl_dec),
        .i_rdata_raw (bus_rdata),
        .o_done      (o_done),
        .o_rdata     (o_rdata),
        .o_fault     (o_fault)
    );

endmodule

`default_nettype wire

// File: design/main_memory.sv
// data memory, wishbone classic slave
// byte-lane writes, registered read, ack in the cycle after each strobe

`default_nettype none

`include "lsu_defines.svh"

module main_memory (
    input  wire             logic i_clk,
    input  wire             logic i_rst,
    input  wire             logic i_wb_cyc,
    input  wire             logic i_wb_stb,
    input  wire             logic i_wb_we,
    input  lsu_pkg::waddr_t i_wb_addr,
    input  lsu_pkg::word_t  i_wb_data,
    input  lsu_pkg::sel_t   i_wb_sel,
    output logic            o_wb_ack,
    output lsu_pkg::word_t  o_wb_data
);

    // word array, one entry per four bytes
    lsu_pkg::word_t mem [0:`LSU_MEM_BYTES/4-1];

    logic req;
    logic rd;
    logic wr;

    assign req = i_wb_cyc && i_wb_stb;
    assign rd  = req && !i_wb_we;
    assign wr  = req && i_wb_we;

    // one ack per strobe, no stall
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_wb_ack <= 1'b0;
        else
            o_wb_ack <= req;
    end

    // registered read so the array maps onto block ram
    always_ff @(posedge i_clk)
    begin
        if (rd)
            o_wb_data <= mem[i_wb_addr];
    end

    // only the selected lanes change
    always_ff @(posedge i_clk)
    begin
        if (wr)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (i_wb_sel[i])
                    mem[i_wb_addr][8*i +: 8] <= i_wb_data[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/lsu_pkg.sv
design/lsu_decode.sv
design/lsu_execute.sv
design/main_memory.sv
design/lsu_result.sv
design/lsu_top.sv
sim/lsu_props.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

// File: sim/lsu_checker.sv
// LSU result checker
// tracks accepted requests, keeps a byte model of the data memory
// and compares every completion with it

`default_nettype none

`include "lsu_defines.svh"

module lsu_checker (
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire logic        i_req_valid,
    input  lsu_pkg::lsu_req_t i_req,
    input  wire logic        i_busy,
    input  wire logic        i_done,
    input  lsu_pkg::word_t   i_rdata,
    input  wire logic        i_fault,
    input  wire logic        i_report,
    input  int               i_missing,
    input  int               i_prop_fails,
    output int               o_errors
);

    timeunit 1ns;
    timeprecision 1ps;

    // accepted request and the edge it was taken on
    typedef struct packed {
        lsu_pkg::lsu_req_t req;
        logic [31:0]       cycle;
    } pend_t;

    pend_t      pend [$];
    logic [7:0] mem_model [`LSU_MEM_BYTES];   // unwritten bytes stay x
    int         cycle = 0;
    int         errors = 0;
    int         n_done = 0;
    int         n_accepted = 0;
    int         n_ignored = 0;
    logic       reported = 1'b0;

    assign o_errors = errors + i_missing + i_prop_fails;

    // low two funct3 bits are log2 of the access size
    function automatic int access_bytes(input logic [2:0] f3);
        return 1 << f3[1:0];
    endfunction

    function automatic logic misaligned(input lsu_pkg::lsu_req_t r);
        return (r.addr % access_bytes(r.funct3)) != 0;
    endfunction

    function automatic logic [31:0] load_value(input lsu_pkg::lsu_req_t r);
        int          n;
        logic [31:0] v;
        n = access_bytes(r.funct3);
        v = '0;
        for (int k = 0; k < n; k++)
            v[8*k +: 8] = mem_model[r.addr + k];
        // funct3 bit 2 clear means signed
        if (!r.funct3[2] && n < 4 && v[8*n-1])
            v = v | (32'hffff_ffff << (8 * n));
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got, input int num);
        if (got !== exp)
        begin
            $display("ERR %s exp 0x%08h got 0x%08h (request %0d)", name, exp, got, num);
            errors++;
        end
    endtask

    task automatic complete();
        pend_t       p;
        logic        mis;
        logic [31:0] exp_data;
        if (pend.size() == 0)
        begin
            $display("completion seen with no accepted request");
            errors++;
        end
        else
        begin
            p        = pend.pop_front();
            mis      = misaligned(p.req);
            exp_data = '0;
            if (!mis && p.req.is_store)
            begin
                for (int k = 0; k < access_bytes(p.req.funct3); k++)
                    mem_model[p.req.addr + k] = p.req.wdata[8*k +: 8];
            end
            else if (!mis)
                exp_data = load_value(p.req);
            check_value("o_rdata", exp_data, i_rdata, n_done);
            check_value("o_fault", {31'd0, mis}, {31'd0, i_fault}, n_done);
            // done is seen one edge after the edge that set it
            check_value("o_done latency", mis ? 2 : 3, cycle - p.cycle - 1, n_done);
            n_done++;
        end
    endtask

    always @(posedge i_clk)
    begin
        pend_t p;
        cycle++;
        if (!i_rst)
        begin
            // busy spans every cycle from acceptance up to done
            if (pend.size() != 0 && !i_done)
                check_value("o_busy", 32'd1, {31'd0, i_busy}, n_done);
            if (i_done)
                complete();
            // quiet from reset until the first request
            if (n_accepted == 0)
            begin
                check_value("o_busy", 32'd0, {31'd0, i_busy}, 0);
                check_value("o_done", 32'd0, {31'd0, i_done}, 0);
            end
            if (i_req_valid && !i_busy)
            begin
                p.req   = i_req;
                p.cycle = cycle;
                pend.push_back(p);
                n_accepted++;
            end
            else if (i_req_valid)
                n_ignored++;
        end
        if (i_report && !reported)
        begin
            reported = 1'b1;
            if (pend.size() != 0)
            begin
                $display("%0d accepted requests never completed", pend.size());
                errors++;
            end
            $write("checker: %0d accepted, %0d completed, %0d ignored, ",
                   n_accepted, n_done, n_ignored);
            $display("%0d errors, %0d missing, %0d assertion failures",
                     errors, i_missing, i_prop_fails);
        end
    end

endmodule

`default_nettype wire

// File: sim/lsu_input.txt
# op: 0 load, 1 store, 2 store strobed while the previous request is busy
# op funct3 addr wdata, all hex
1 2 100 deadbeef
0 2 100 00000000
1 2 104 00000000
1 0 104 a5a5a511
1 0 105 a5a5a522
1 0 106 a5a5a533
1 0 107 a5a5a544
0 2 104 00000000
1 2 108 80f17e93
0 0 108 00000000
0 4 108 00000000
0 0 109 00000000
0 0 10b 00000000
0 4 10b 00000000
0 1 108 00000000
0 1 10a 00000000
0 5 10a 00000000
1 2 10c 00000000
1 1 10e 1234abcd
0 2 10c 00000000
0 1 101 00000000
0 2 102 00000000
1 2 103 ffffffff
1 1 105 0000ffff
0 2 100 00000000
0 2 104 00000000
1 2 110 01234567
2 2 110 ffffffff
0 2 110 00000000
0 2 111 00000000
2 0 110 000000ee
0 2 110 00000000

// File: sim/lsu_props.sv
// LSU protocol properties
// wishbone strobe and ack rules and the completion latency at the top level

`default_nettype none

module lsu_props (
    input wire logic         i_clk,
    input wire logic         i_rst,
    input wire logic         i_req_valid,
    input lsu_pkg::lsu_req_t i_req,
    input wire logic         i_busy,
    input wire logic         i_done,
    input wire logic         i_wb_cyc,
    input wire logic         i_wb_stb,
    input wire logic         i_wb_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [2:0] f3;
    logic       accept;
    logic       misaligned;
    // number of failed assertions
    int         fail_count = 0;

    assign f3     = i_req.funct3;
    assign accept = i_req_valid && !i_busy;
    // halves need an even address, words a multiple of four
    assign misaligned = (f3[1:0] == 2'd1) ? i_req.addr[0] :
                        (f3[1:0] == 2'd2) ? (i_req.addr[1:0] != 2'b00) : 1'b0;

    assert property (@(posedge i_clk) disable iff (i_rst) i_wb_stb |-> i_wb_cyc)
        else
        begin
            fail_count++;
            $error("wishbone stb high without cyc");
        end

    // memory answers each strobe on the next edge and never on its own
    assert property (@(posedge i_clk) disable iff (i_rst) i_wb_stb |=> i_wb_ack)
        else
        begin
            fail_count++;
            $error("no ack in the cycle after stb");
        end
    assert property (@(posedge i_clk) disable iff (i_rst) i_wb_ack |-> $past(i_wb_stb))
        else
        begin
            fail_count++;
            $error("ack without stb in the previous cycle");
        end

    // done is set on the third edge after an aligned acceptance, second if misaligned
    assert property (@(posedge i_clk) disable iff (i_rst)
        accept && !misaligned |=> !i_done [*3] ##1 i_done)
        else
        begin
            fail_count++;
            $error("aligned access did not complete after 3 cycles");
        end
    assert property (@(posedge i_clk) disable iff (i_rst)
        accept && misaligned |=> !i_done [*2] ##1 i_done)
        else
        begin
            fail_count++;
            $error("misaligned access did not complete after 2 cycles");
        end

    assert property (@(posedge i_clk) disable iff (i_rst) i_done |=> !i_done)
        else
        begin
            fail_count++;
            $error("done high for two cycles in a row");
        end

endmodule

`default_nettype wire

// File: sim/lsu_tb.sv
// LSU testbench
// reads requests from the data file, drives them on the falling clock edge
// and waits for each completion while the checker compares the results

`default_nettype none

module lsu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_REQS   = 64;
    localparam int DONE_WAIT  = 10;

    // one data file line
    typedef struct packed {
        logic [1:0]  op;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] wdata;
    } stim_t;

    logic              clk;
    logic              rst;
    logic              req_valid;
    lsu_pkg::lsu_req_t req;
    logic              busy;
    logic              done;
    lsu_pkg::word_t    rdata;
    logic              fault;
    logic              report;
    logic              loaded;
    int                missing;
    int                check_errors;
    int                n_reqs;
    int                idx;
    int                cur;
    stim_t             stim [MAX_REQS];

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    lsu_top dut_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_busy      (busy),
        .o_done      (done),
        .o_rdata     (rdata),
        .o_fault     (fault)
    );

    lsu_checker u_checker (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .i_busy       (busy),
        .i_done       (done),
        .i_rdata      (rdata),
        .i_fault      (fault),
        .i_report     (report),
        .i_missing    (missing),
        .i_prop_fails (dut_i.u_props.fail_count),
        .o_errors     (check_errors)
    );

    // properties sit inside the DUT so they can see the wishbone wires
    bind lsu_top lsu_props u_props (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .i_busy      (o_busy),
        .i_done      (o_done),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_ack    (wb_ack)
    );

    // lines that do not hold four hex fields are comments
    task automatic read_stimulus();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_f3;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        fd = $fopen("sim/lsu_input.txt", "r");
        if (fd == 0)
            $display("cannot open sim/lsu_input.txt");
        else
        begin
            while (!$feof(fd) && n_reqs < MAX_REQS)
            begin
                line = "";
                rc = $fgets(line, fd);
                rc = $sscanf(line, "%h %h %h %h", f_op, f_f3, f_addr, f_wdata);
                if (rc == 4)
                begin
                    stim[n_reqs] = {f_op[1:0], f_f3[2:0], f_addr, f_wdata};
                    n_reqs++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic put_request(input stim_t s);
        req_valid    = 1'b1;
        req.is_store = (s.op != 2'd0);
        req.funct3   = lsu_pkg::funct3_t'(s.funct3);
        req.addr     = lsu_pkg::addr_t'(s.addr);
        req.wdata    = s.wdata;
    endtask

    // done is sampled on falling edges where it is stable
    task automatic wait_done(input int num);
        int waited;
        waited = 0;
        while (!done && waited < DONE_WAIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!done)
        begin
            $display("no completion for request %0d", num);
            missing++;
        end
    endtask

    initial
    begin
        req_valid = 1'b0;
        req       = '0;
        rst       = 1'b1;
        report    = 1'b0;
        loaded    = 1'b0;
        missing   = 0;
        n_reqs    = 0;
        read_stimulus();
        loaded = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        idx = 0;
        while (idx < n_reqs)
        begin
            while (busy)
                @(negedge clk);
            cur = idx;
            put_request(stim[idx]);
            @(negedge clk);
            req_valid = 1'b0;
            // op 2 is strobed into the busy window and must be dropped
            if (idx + 1 < n_reqs && stim[idx + 1].op == 2'd2)
            begin
                put_request(stim[idx + 1]);
                @(negedge clk);
                req_valid = 1'b0;
                idx++;
            end
            wait_done(cur);
            idx++;
        end
        repeat (2) @(negedge clk);
        report = 1'b1;
        #(CLK_PERIOD);
        if (n_reqs == 0)
            $display("no requests read from sim/lsu_input.txt");
        if (n_reqs > 0 && check_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // about six cycles per request plus reset and drain
    initial
    begin
        wait (loaded);
        repeat (n_reqs * 6 + 20) @(posedge clk);
        $display("watchdog expired after %0d cycles", n_reqs * 6 + 20);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
